// ==== bench/tb_core_mem_checks.svh ====
/* Reference word memory and typed compare tasks for the memory testbench.
   Included inside the testbench module, after its failure task. */
`ifndef TB_CORE_MEM_CHECKS_SVH
`define TB_CORE_MEM_CHECKS_SVH

// Mirror of the internal memory kept in request order
logic [DATA_W-1:0] ref_mem [MEM_WORDS];

task automatic ref_clear();
  for (int i = 0; i < MEM_WORDS; i++) begin
    ref_mem[i] = '0;
  end
endtask

// Expected read data for one access
// Writes land in the mirror as they are issued
function automatic logic [DATA_W-1:0] ref_access(input mem_op_e op,
    input logic [ADDR_W-1:0] addr, input logic [BE_W-1:0] be,
    input logic [DATA_W-1:0] wdata, input logic ext);
  int unsigned       widx;
  logic [DATA_W-1:0] res;
  widx = addr >> 2;
  res  = '0;
  if (ext) begin
    res = addr ^ 32'hA5A5_A5A5;
  end else if (widx < MEM_WORDS) begin
    if (op == OP_READ) begin
      res = ref_mem[widx];
    end else begin
      for (int b = 0; b < BE_W; b++) begin
        if (be[b]) begin
          ref_mem[widx][b*8 +: 8] = wdata[b*8 +: 8];
        end
      end
    end
  end
  return res;
endfunction

task automatic report_mismatch(input string msg);
  fail_run($sformatf("CHECK FAILED at %0t: %s", $time, msg));
endtask

task automatic check_rsp(input mem_rsp_e got_code, input mem_rsp_e exp_code,
    input logic [TAG_W-1:0] got_tag, input logic [TAG_W-1:0] exp_tag,
    input logic [DATA_W-1:0] got_data, input logic [DATA_W-1:0] exp_data);
  if (got_code !== exp_code || got_tag !== exp_tag || got_data !== exp_data) begin
    report_mismatch($sformatf("response tag %0h %s data %h, expected tag %0h %s data %h",
                              got_tag, got_code.name(), got_data,
                              exp_tag, exp_code.name(), exp_data));
  end
endtask

task automatic check_ext(input mem_op_e got_op, input mem_op_e exp_op,
    input logic [ADDR_W-1:0] got_addr, input logic [ADDR_W-1:0] exp_addr,
    input logic [BE_W-1:0] got_be, input logic [BE_W-1:0] exp_be,
    input logic [DATA_W-1:0] got_wdata, input logic [DATA_W-1:0] exp_wdata,
    input logic [TAG_W-1:0] got_tag, input logic [TAG_W-1:0] exp_tag);
  if (got_op !== exp_op || got_addr !== exp_addr || got_be !== exp_be ||
      got_wdata !== exp_wdata || got_tag !== exp_tag) begin
    report_mismatch({$sformatf("external access %s addr %h be %h wdata %h tag %0h",
                               got_op.name(), got_addr, got_be, got_wdata, got_tag),
                     $sformatf(", expected %s addr %h be %h wdata %h tag %0h",
                               exp_op.name(), exp_addr, exp_be, exp_wdata, exp_tag)});
  end
endtask

task automatic check_exit(input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    report_mismatch($sformatf("exit_o is %h, expected %h", got, exp));
  end
endtask

task automatic check_count(input string what, input logic [31:0] got,
    input logic [31:0] exp);
  if (got !== exp) begin
    report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
  end
endtask

`endif

// ==== bench/tb_core_mem.sv ====
/* Testbench for the memory subsystem top. Runs a stimulus table through the
   credit-based request channel, models the external slave and drives commits. */
`timescale 1ns/1ps

module tb_core_mem;
  import mem_bus_pkg::*;
  import trace_pkg::*;

  localparam int NUM_ROWS        = 27;
  localparam int HOLD_ROWS       = 2 * CREDITS;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * 40 + 500;

  typedef struct {
    mem_op_e           op;
    logic [ADDR_W-1:0] addr;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
    logic [TAG_W-1:0]  tag;
    logic              sel_ext;
    mem_rsp_e          code;
  } stim_t;

  typedef struct {
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] data;
    mem_rsp_e          code;
  } exp_rsp_t;

  typedef struct {
    logic [ADDR_W-1:0] addr;
    logic [TAG_W-1:0]  tag;
    int                due;
  } ext_pend_t;

  // DUT inputs start idle at time zero
  logic              clk_i          = 1'b0;
  logic              rst_n_i        = 1'b0;
  logic              sel_ext_i      = 1'b0;
  logic              req_valid_i    = 1'b0;
  mem_op_e           req_op_i       = OP_READ;
  logic [ADDR_W-1:0] req_addr_i     = '0;
  logic [BE_W-1:0]   req_be_i       = '0;
  logic [DATA_W-1:0] req_wdata_i    = '0;
  logic [TAG_W-1:0]  req_tag_i      = '0;
  logic              rsp_credit_i   = 1'b0;
  logic              ext_rvalid_i   = 1'b0;
  logic [DATA_W-1:0] ext_rdata_i    = '0;
  logic [TAG_W-1:0]  ext_rtag_i     = '0;
  logic              commit_valid_i = 1'b0;
  commit_rec_t       commit_i       = '0;

  logic              req_credit_o;
  logic              rsp_valid_o;
  logic [DATA_W-1:0] rsp_rdata_o;
  mem_rsp_e          rsp_code_o;
  logic [TAG_W-1:0]  rsp_tag_o;
  logic              ext_valid_o;
  mem_op_e           ext_op_o;
  logic [ADDR_W-1:0] ext_addr_o;
  logic [BE_W-1:0]   ext_be_o;
  logic [DATA_W-1:0] ext_wdata_o;
  logic [TAG_W-1:0]  ext_tag_o;
  logic [31:0]       exit_o;
  logic [31:0]       retired_o;

  stim_t       stim [NUM_ROWS];
  exp_rsp_t    exp_q [$];
  ext_pend_t   ext_q [$];
  // Accesses expected on the external port in order
  stim_t       ext_exp_q [$];
  int          issued = 0;
  int          returned = 0;
  int          rsp_seen = 0;
  int          given = 0;
  logic        credit_hold = 1'b0;
  int          cyc = 0;
  int          seed = 52517;
  logic [31:0] exp_retired = '0;
  logic [31:0] exp_exit = '0;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "stopping at the first error");
  endtask

  `include "tb_core_mem_checks.svh"

  always #2 clk_i = ~clk_i;

  core_mem_top u_dut (.*);

  // ----------------------------------------
  // External slave answering in order after 1 to 4 cycles
  // ----------------------------------------
  always @(posedge clk_i) begin : ext_slave
    ext_pend_t ent;
    stim_t     want;
    cyc++;
    if (ext_q.size() > 0 && cyc >= ext_q[0].due) begin
      ent = ext_q.pop_front();
      ext_rvalid_i <= 1'b1;
      ext_rdata_i  <= ent.addr ^ 32'hA5A5_A5A5;
      ext_rtag_i   <= ent.tag;
    end else begin
      ext_rvalid_i <= 1'b0;
    end
    if (rst_n_i && ext_valid_o) begin
      if (ext_exp_q.size() == 0) begin
        fail_run("an external access appeared with no external request outstanding");
      end else begin
        want = ext_exp_q.pop_front();
        check_ext(ext_op_o, want.op, ext_addr_o, want.addr, ext_be_o, want.be,
                  ext_wdata_o, want.wdata, ext_tag_o, want.tag);
      end
      ent.addr = ext_addr_o;
      ent.tag  = ext_tag_o;
      ent.due  = cyc + 1 + int'($unsigned($random(seed)) % 4);
      ext_q.push_back(ent);
    end
  end

  // Request credits coming back from the bridge
  always @(posedge clk_i) begin
    if (rst_n_i && req_credit_o) begin
      returned++;
    end
  end

  // Response checking and one credit back per response
  always @(posedge clk_i) begin : rsp_side
    exp_rsp_t e;
    if (rst_n_i && rsp_valid_o) begin
      if (exp_q.size() == 0) begin
        fail_run("a response arrived with no request outstanding");
      end else begin
        e = exp_q.pop_front();
        check_rsp(rsp_code_o, e.code, rsp_tag_o, e.tag, rsp_rdata_o, e.data);
        rsp_seen++;
      end
    end
    if (!credit_hold && given < rsp_seen) begin
      rsp_credit_i <= 1'b1;
      given++;
    end else begin
      rsp_credit_i <= 1'b0;
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    fail_run("watchdog expired before the tests finished");
  end

  task automatic set_row(input int i, input mem_op_e op, input logic [ADDR_W-1:0] addr,
      input logic [BE_W-1:0] be, input logic [DATA_W-1:0] wdata,
      input logic [TAG_W-1:0] tag, input logic sel, input mem_rsp_e code);
    stim[i] = '{op, addr, be, wdata, tag, sel, code};
  endtask

  task automatic load_table();
    // Byte-enable writes and reads of the merged words
    set_row(0,  OP_WRITE, 32'h0000_0000, 4'hF, 32'h1122_3344, 4'd0, 1'b0, RSP_OKAY);
    set_row(1,  OP_WRITE, 32'h0000_0004, 4'h3, 32'hAABB_CCDD, 4'd1, 1'b0, RSP_OKAY);
    set_row(2,  OP_WRITE, 32'h0000_0008, 4'hC, 32'h5566_7788, 4'd2, 1'b0, RSP_OKAY);
    set_row(3,  OP_WRITE, 32'h0000_000C, 4'h5, 32'h99AA_BBCC, 4'd3, 1'b0, RSP_OKAY);
    set_row(4,  OP_WRITE, 32'h0000_0000, 4'h2, 32'h0000_EE00, 4'd4, 1'b0, RSP_OKAY);
    set_row(5,  OP_READ,  32'h0000_0000, 4'h0, 32'h0,         4'd5, 1'b0, RSP_OKAY);
    set_row(6,  OP_READ,  32'h0000_0004, 4'h0, 32'h0,         4'd6, 1'b0, RSP_OKAY);
    set_row(7,  OP_READ,  32'h0000_0008, 4'h0, 32'h0,         4'd7, 1'b0, RSP_OKAY);
    set_row(8,  OP_READ,  32'h0000_000C, 4'h0, 32'h0,         4'd8, 1'b0, RSP_OKAY);
    // Out of range accesses and reads of the last word and word 0
    set_row(9,  OP_WRITE, 32'h0000_0400, 4'hF, 32'hDEAD_BEEF, 4'd9, 1'b0, RSP_ERR);
    set_row(10, OP_READ,  32'h0000_07FC, 4'h0, 32'h0,        4'd10, 1'b0, RSP_ERR);
    set_row(11, OP_READ,  32'h0000_03FC, 4'h0, 32'h0,        4'd11, 1'b0, RSP_OKAY);
    set_row(12, OP_READ,  32'h0000_0000, 4'h0, 32'h0,        4'd12, 1'b0, RSP_OKAY);
    // External slave
    set_row(13, OP_READ,  32'h0000_0000, 4'h0, 32'h0,        4'd13, 1'b1, RSP_OKAY);
    set_row(14, OP_READ,  32'h0000_0010, 4'h0, 32'h0,        4'd14, 1'b1, RSP_OKAY);
    set_row(15, OP_WRITE, 32'h0000_0000, 4'hF, 32'hFFFF_FFFF, 4'd15, 1'b1, RSP_OKAY);
    set_row(16, OP_READ,  32'h0000_123C, 4'h0, 32'h0,         4'd0, 1'b1, RSP_OKAY);
    set_row(17, OP_READ,  32'h0000_0004, 4'h0, 32'h0,         4'd1, 1'b1, RSP_OKAY);
    set_row(18, OP_READ,  32'h0000_0000, 4'h0, 32'h0,         4'd2, 1'b0, RSP_OKAY);
    // Sent while response credits are held
    set_row(19, OP_READ,  32'h0000_0000, 4'h0, 32'h0,         4'd3, 1'b0, RSP_OKAY);
    set_row(20, OP_READ,  32'h0000_0004, 4'h0, 32'h0,         4'd4, 1'b0, RSP_OKAY);
    set_row(21, OP_READ,  32'h0000_0008, 4'h0, 32'h0,         4'd5, 1'b0, RSP_OKAY);
    set_row(22, OP_READ,  32'h0000_000C, 4'h0, 32'h0,         4'd6, 1'b0, RSP_OKAY);
    set_row(23, OP_WRITE, 32'h0000_0010, 4'hF, 32'h0BAD_F00D, 4'd7, 1'b0, RSP_OKAY);
    set_row(24, OP_READ,  32'h0000_0010, 4'h0, 32'h0,         4'd8, 1'b0, RSP_OKAY);
    set_row(25, OP_READ,  32'h0000_03FC, 4'h0, 32'h0,         4'd9, 1'b0, RSP_OKAY);
    set_row(26, OP_READ,  32'h0000_0000, 4'h0, 32'h0,        4'd10, 1'b0, RSP_OKAY);
  endtask

  task automatic issue_row(input int i);
    exp_rsp_t e;
    while (issued - returned >= CREDITS) @(posedge clk_i);
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_op_i    <= stim[i].op;
    req_addr_i  <= stim[i].addr;
    req_be_i    <= stim[i].be;
    req_wdata_i <= stim[i].wdata;
    req_tag_i   <= stim[i].tag;
    issued++;
    e.tag  = stim[i].tag;
    e.code = stim[i].code;
    e.data = ref_access(stim[i].op, stim[i].addr, stim[i].be, stim[i].wdata,
                        stim[i].sel_ext);
    exp_q.push_back(e);
    if (stim[i].sel_ext) begin
      ext_exp_q.push_back(stim[i]);
    end
    @(posedge clk_i);
    req_valid_i <= 1'b0;
  endtask

  // Wait until every request is answered and every credit handed back
  task automatic drain();
    while (rsp_seen != issued || given != rsp_seen) @(posedge clk_i);
    repeat (2) @(posedge clk_i);
  endtask

  task automatic drive_commit(input logic valid, input commit_op_e op,
      input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    commit_rec_t rec;
    rec.op   = op;
    rec.addr = addr;
    rec.data = data;
    @(posedge clk_i);
    commit_valid_i <= valid;
    commit_i       <= rec;
    @(posedge clk_i);
    commit_valid_i <= 1'b0;
    if (valid) begin
      exp_retired = exp_retired + 32'd1;
    end
    if (valid && op == C_STORE && addr == EXIT_ADDR && data[0] && exp_exit == '0) begin
      exp_exit = data;
    end
    #1;
    check_count("retired_o", retired_o, exp_retired);
    check_exit(exit_o, exp_exit);
  endtask

  initial begin : main_seq
    int seen0;
    int ret0;
    ref_clear();
    load_table();
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    #1;
    check_count("req_credit_o after reset", 32'(req_credit_o), 32'd0);
    check_count("rsp_valid_o after reset", 32'(rsp_valid_o), 32'd0);
    check_count("ext_valid_o after reset", 32'(ext_valid_o), 32'd0);
    check_exit(exit_o, 32'd0);

    // Switch target only with nothing in flight
    for (int i = 0; i < NUM_ROWS - HOLD_ROWS; i++) begin
      if (stim[i].sel_ext != sel_ext_i) begin
        drain();
        @(posedge clk_i);
        sel_ext_i <= stim[i].sel_ext;
      end
      issue_row(i);
    end
    drain();

    // ----------------------------------------
    // Response credits held low
    // ----------------------------------------
    seen0       = rsp_seen;
    ret0        = returned;
    credit_hold = 1'b1;
    for (int i = NUM_ROWS - HOLD_ROWS; i < NUM_ROWS; i++) begin
      issue_row(i);
    end
    while (rsp_seen - seen0 < CREDITS) @(posedge clk_i);
    repeat (16) @(posedge clk_i);
    check_count("responses with credits held", rsp_seen - seen0, CREDITS);
    check_count("req_credit_o pulses with credits held", returned - ret0, CREDITS);
    credit_hold = 1'b0;
    drain();
    check_count("req_credit_o pulses in total", returned, NUM_ROWS);

    // Commit stream where only the first odd exit store sets the code
    drive_commit(1'b1, C_ALU,   32'h0000_0000, 32'h0000_0000);
    drive_commit(1'b1, C_LOAD,  32'h0000_0040, 32'h1234_5678);
    drive_commit(1'b0, C_STORE, EXIT_ADDR,     32'h0000_0003);
    drive_commit(1'b1, C_STORE, 32'h0000_0044, 32'h0000_0007);
    drive_commit(1'b1, C_STORE, EXIT_ADDR,     32'h0000_0010);
    drive_commit(1'b1, C_ECALL, 32'h0000_0000, 32'h0000_0000);
    drive_commit(1'b1, C_STORE, EXIT_ADDR,     32'h0000_002B);
    drive_commit(1'b1, C_STORE, EXIT_ADDR,     32'h0000_0055);
    drive_commit(1'b1, C_ALU,   32'h0000_0000, 32'h0000_0000);

    $display("sim passed");
    $finish;
  end

endmodule

// ==== design/bus_to_mem.sv ====
/* Request bridge with credit flow control on both channels.
   Queues incoming word requests, issues them as single-beat accesses while a
   response credit is free, and registers the returned response. */
`timescale 1ns/1ps

module bus_to_mem (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             req_valid_i,
  input  mem_bus_pkg::mem_op_e             req_op_i,
  input  logic [mem_bus_pkg::ADDR_W-1:0]   req_addr_i,
  input  logic [mem_bus_pkg::BE_W-1:0]     req_be_i,
  input  logic [mem_bus_pkg::DATA_W-1:0]   req_wdata_i,
  input  logic [mem_bus_pkg::TAG_W-1:0]    req_tag_i,
  output logic                             req_credit_o,
  output logic                             rsp_valid_o,
  output logic [mem_bus_pkg::DATA_W-1:0]   rsp_rdata_o,
  output mem_bus_pkg::mem_rsp_e            rsp_code_o,
  output logic [mem_bus_pkg::TAG_W-1:0]    rsp_tag_o,
  input  logic                             rsp_credit_i,
  mem_req_if.master                        mem
);
  import mem_bus_pkg::*;

  typedef struct packed {
    mem_op_e           op;
    logic [ADDR_W-1:0] addr;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
    logic [TAG_W-1:0]  tag;
  } req_ent_t;

  req_ent_t              fifo_q [CREDITS];
  req_ent_t              head;
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [CREDIT_W-1:0]   fifo_cnt;
  logic [CREDIT_W-1:0]   rsp_cred;
  logic                  push;
  logic                  pop;

  // ----------------------------------------
  // Request FIFO
  // ----------------------------------------
  assign push = req_valid_i;
  // Only issue with a slot free at the receiver
  assign pop  = (fifo_cnt != '0) && (rsp_cred != '0);

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr] <= '{req_op_i, req_addr_i, req_be_i, req_wdata_i, req_tag_i};
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == FIFO_PTR_W'(CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == FIFO_PTR_W'(CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
      end
      fifo_cnt <= fifo_cnt + CREDIT_W'(push) - CREDIT_W'(pop);
    end
  end

  // Issue straight from the head, credit returns as the entry leaves
  assign head         = fifo_q[rd_ptr];
  assign mem.valid    = pop;
  assign mem.op       = head.op;
  assign mem.addr     = head.addr;
  assign mem.be       = head.be;
  assign mem.wdata    = head.wdata;
  assign mem.tag      = head.tag;
  assign req_credit_o = pop;

  // ----------------------------------------
  // Response credits and output register
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_cred    <= CREDIT_W'(CREDITS);
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_cred    <= rsp_cred - CREDIT_W'(pop) + CREDIT_W'(rsp_credit_i);
      rsp_valid_o <= mem.rvalid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem.rvalid) begin
      rsp_rdata_o <= mem.rdata;
      rsp_code_o  <= mem.rsp;
      rsp_tag_o   <= mem.rtag;
    end
  end

  // Sender side spent a credit it did not have
  a_no_overflow: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i |-> (fifo_cnt != CREDIT_W'(CREDITS))
  ) else $error("request arrived while the FIFO was full");

  // Receiver returned more credits than it was given
  a_rsp_cred_max: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rsp_cred <= CREDIT_W'(CREDITS)
  ) else $error("response credit count above CREDITS");

endmodule

// ==== design/commit_tracer.sv ====
/* Watches the retired-instruction stream, counts commits and captures the
   end-of-test code written to EXIT_ADDR. */
`timescale 1ns/1ps

module commit_tracer (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     commit_valid_i,
  input  trace_pkg::commit_rec_t   commit_i,
  output logic [31:0]              exit_o,
  output logic [31:0]              retired_o
);
  import trace_pkg::*;

  logic exit_hit;
  logic exit_done;

  // Exit store needs bit 0 set, so a zero code never ends a test
  assign exit_hit = commit_valid_i &&
                    (commit_i.op == C_STORE) &&
                    (commit_i.addr == EXIT_ADDR) &&
                    commit_i.data[0];

  // Any latched code has bit 0 set
  assign exit_done = exit_o[0];

  // ----------------------------------------
  // Retire counter
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      retired_o <= '0;
    end else if (commit_valid_i) begin
      retired_o <= retired_o + 32'd1;
    end
  end

  // ----------------------------------------
  // Exit code capture
  // ----------------------------------------
  // First exit store wins
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_o <= '0;
    end else if (exit_hit && !exit_done) begin
      exit_o <= commit_i.data;
    end
  end

  // Core should never report an ECALL at the exit address
  a_ecall_addr: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (commit_valid_i && (commit_i.op == C_ECALL)) |-> (commit_i.addr != EXIT_ADDR)
  ) else $error("ECALL commit carries EXIT_ADDR");

endmodule

// ==== design/core_mem_top.sv ====
/* Memory subsystem top: request bridge, route stage, word memory and commit
   tracer, with plain credit-based ports toward the harness. */
`timescale 1ns/1ps

module core_mem_top (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             sel_ext_i,
  // Request channel
  input  logic                             req_valid_i,
  input  mem_bus_pkg::mem_op_e             req_op_i,
  input  logic [mem_bus_pkg::ADDR_W-1:0]   req_addr_i,
  input  logic [mem_bus_pkg::BE_W-1:0]     req_be_i,
  input  logic [mem_bus_pkg::DATA_W-1:0]   req_wdata_i,
  input  logic [mem_bus_pkg::TAG_W-1:0]    req_tag_i,
  output logic                             req_credit_o,
  // Response channel
  output logic                             rsp_valid_o,
  output logic [mem_bus_pkg::DATA_W-1:0]   rsp_rdata_o,
  output mem_bus_pkg::mem_rsp_e            rsp_code_o,
  output logic [mem_bus_pkg::TAG_W-1:0]    rsp_tag_o,
  input  logic                             rsp_credit_i,
  // External slave port
  output logic                             ext_valid_o,
  output mem_bus_pkg::mem_op_e             ext_op_o,
  output logic [mem_bus_pkg::ADDR_W-1:0]   ext_addr_o,
  output logic [mem_bus_pkg::BE_W-1:0]     ext_be_o,
  output logic [mem_bus_pkg::DATA_W-1:0]   ext_wdata_o,
  output logic [mem_bus_pkg::TAG_W-1:0]    ext_tag_o,
  input  logic                             ext_rvalid_i,
  input  logic [mem_bus_pkg::DATA_W-1:0]   ext_rdata_i,
  input  logic [mem_bus_pkg::TAG_W-1:0]    ext_rtag_i,
  // Commit stream
  input  logic                             commit_valid_i,
  input  trace_pkg::commit_rec_t           commit_i,
  output logic [31:0]                      exit_o,
  output logic [31:0]                      retired_o
);

  // Bridge to route, route to memory
  mem_req_if up_bus ();
  mem_req_if sram_bus ();

  // ----------------------------------------
  // Memory path
  // ----------------------------------------
  bus_to_mem u_bus_to_mem (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_op_i     (req_op_i),
    .req_addr_i   (req_addr_i),
    .req_be_i     (req_be_i),
    .req_wdata_i  (req_wdata_i),
    .req_tag_i    (req_tag_i),
    .req_credit_o (req_credit_o),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_rdata_o  (rsp_rdata_o),
    .rsp_code_o   (rsp_code_o),
    .rsp_tag_o    (rsp_tag_o),
    .rsp_credit_i (rsp_credit_i),
    .mem          (up_bus)
  );

  mem_route u_mem_route (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .sel_ext_i    (sel_ext_i),
    .up           (up_bus),
    .down         (sram_bus),
    .ext_valid_o  (ext_valid_o),
    .ext_op_o     (ext_op_o),
    .ext_addr_o   (ext_addr_o),
    .ext_be_o     (ext_be_o),
    .ext_wdata_o  (ext_wdata_o),
    .ext_tag_o    (ext_tag_o),
    .ext_rvalid_i (ext_rvalid_i),
    .ext_rdata_i  (ext_rdata_i),
    .ext_rtag_i   (ext_rtag_i)
  );

  word_sram u_word_sram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .mem     (sram_bus)
  );

  // ----------------------------------------
  // Commit trace
  // ----------------------------------------
  commit_tracer u_commit_tracer (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .commit_valid_i (commit_valid_i),
    .commit_i       (commit_i),
    .exit_o         (exit_o),
    .retired_o      (retired_o)
  );

endmodule

// ==== design/mem_bus_pkg.sv ====
/* Bus widths, credit depth, memory size and access encodings shared by the
   bridge, the route stage and the word memory. Import it in the module body. */
package mem_bus_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;
  localparam int TAG_W  = 4;

  // Byte offset bits inside one word
  localparam int BYTE_OFS = $clog2(BE_W);

  // ----------------------------------------
  // Flow control and memory size
  // ----------------------------------------
  // FIFO depth, also the starting credit count on both channels
  localparam int CREDITS = 4;

  // Wide enough to hold 0 .. CREDITS
  localparam int CREDIT_W   = $clog2(CREDITS + 1);
  localparam int FIFO_PTR_W = $clog2(CREDITS);

  localparam int MEM_WORDS  = 256;
  localparam int WORD_IDX_W = $clog2(MEM_WORDS);

  // ----------------------------------------
  // Encodings
  // ----------------------------------------
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mem_op_e;

  typedef enum logic {
    RSP_OKAY = 1'b0,
    RSP_ERR  = 1'b1
  } mem_rsp_e;

endpackage

// ==== design/mem_req_if.sv ====
/* Single-beat word access bus with a request side and a response side.
   The route modport sits on both sides of the route stage, so it is bidirectional. */
`timescale 1ns/1ps

interface mem_req_if;
  import mem_bus_pkg::*;

  // Request toward the memory side
  wire logic              valid;
  wire mem_op_e           op;
  wire logic [ADDR_W-1:0] addr;
  wire logic [BE_W-1:0]   be;
  wire logic [DATA_W-1:0] wdata;
  wire logic [TAG_W-1:0]  tag;

  // Response back, exactly one per access
  wire logic              rvalid;
  wire logic [DATA_W-1:0] rdata;
  wire mem_rsp_e          rsp;
  wire logic [TAG_W-1:0]  rtag;

  modport master (
    output valid, op, addr, be, wdata, tag,
    input  rvalid, rdata, rsp, rtag
  );

  modport slave (
    input  valid, op, addr, be, wdata, tag,
    output rvalid, rdata, rsp, rtag
  );

  modport route (
    inout valid, op, addr, be, wdata, tag,
    inout rvalid, rdata, rsp, rtag
  );

endinterface

// ==== design/mem_route.sv ====
/* Steers each access to the internal memory or the external slave port and
   muxes the answer back. Both directions are combinational. */
`timescale 1ns/1ps

module mem_route (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             sel_ext_i,
  mem_req_if.route                         up,
  mem_req_if.route                         down,
  output logic                             ext_valid_o,
  output mem_bus_pkg::mem_op_e             ext_op_o,
  output logic [mem_bus_pkg::ADDR_W-1:0]   ext_addr_o,
  output logic [mem_bus_pkg::BE_W-1:0]     ext_be_o,
  output logic [mem_bus_pkg::DATA_W-1:0]   ext_wdata_o,
  output logic [mem_bus_pkg::TAG_W-1:0]    ext_tag_o,
  input  logic                             ext_rvalid_i,
  input  logic [mem_bus_pkg::DATA_W-1:0]   ext_rdata_i,
  input  logic [mem_bus_pkg::TAG_W-1:0]    ext_rtag_i
);
  import mem_bus_pkg::*;

  logic [CREDIT_W-1:0] outstanding;

  // ----------------------------------------
  // Request steering
  // ----------------------------------------
  assign down.valid = up.valid & ~sel_ext_i;
  assign down.op    = up.op;
  assign down.addr  = up.addr;
  assign down.be    = up.be;
  assign down.wdata = up.wdata;
  assign down.tag   = up.tag;

  assign ext_valid_o = up.valid & sel_ext_i;
  assign ext_op_o    = up.op;
  assign ext_addr_o  = up.addr;
  assign ext_be_o    = up.be;
  assign ext_wdata_o = up.wdata;
  assign ext_tag_o   = up.tag;

  // ----------------------------------------
  // Response mux
  // ----------------------------------------
  // External slave never reports an error
  assign up.rvalid = sel_ext_i ? ext_rvalid_i : down.rvalid;
  assign up.rdata  = sel_ext_i ? ext_rdata_i  : down.rdata;
  assign up.rsp    = sel_ext_i ? RSP_OKAY     : down.rsp;
  assign up.rtag   = sel_ext_i ? ext_rtag_i   : down.rtag;

  // Accesses sent but not yet answered
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      outstanding <= '0;
    end else begin
      outstanding <= outstanding + CREDIT_W'(up.valid) - CREDIT_W'(up.rvalid);
    end
  end

  // Switching target mid-flight would lose or misroute an answer
  a_sel_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $changed(sel_ext_i) |-> (outstanding == '0)
  ) else $error("sel_ext_i changed with accesses outstanding");

endmodule

// ==== design/trace_pkg.sv ====
/* Retired-instruction record and end-of-test address for the commit tracer.
   A store of an odd value to EXIT_ADDR ends the test. */
package trace_pkg;

  // Kind of instruction that retired
  typedef enum logic [1:0] {
    C_ALU   = 2'd0,
    C_LOAD  = 2'd1,
    C_STORE = 2'd2,
    C_ECALL = 2'd3
  } commit_op_e;

  // One retired instruction
  // addr and data only mean something for loads and stores
  typedef struct packed {
    commit_op_e                     op;
    logic [mem_bus_pkg::ADDR_W-1:0] addr;
    logic [mem_bus_pkg::DATA_W-1:0] data;
  } commit_rec_t;

  // Store target that carries the exit code
  localparam logic [mem_bus_pkg::ADDR_W-1:0] EXIT_ADDR = 32'h0000_1000;

endpackage

// ==== design/word_sram.sv ====
/* Byte-enabled word memory answering each access one cycle later.
   Out-of-range word indices return an error and leave the array untouched. */
`timescale 1ns/1ps

module word_sram (
  input  logic     clk_i,
  input  logic     rst_n_i,
  mem_req_if.slave mem
);
  import mem_bus_pkg::*;

  logic [DATA_W-1:0]          mem_q [MEM_WORDS];
  logic [ADDR_W-BYTE_OFS-1:0] word_idx;
  logic [WORD_IDX_W-1:0]      idx;
  logic                       in_range;
  logic                       rvalid_q;
  logic [DATA_W-1:0]          rdata_q;
  mem_rsp_e                   rsp_q;
  logic [TAG_W-1:0]           rtag_q;

  assign word_idx = mem.addr[ADDR_W-1:BYTE_OFS];
  assign idx      = word_idx[WORD_IDX_W-1:0];
  assign in_range = word_idx < (ADDR_W - BYTE_OFS)'(MEM_WORDS);

  // Array write, cleared on reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (mem.valid && (mem.op == OP_WRITE) && in_range) begin
      for (int b = 0; b < BE_W; b++) begin
        if (mem.be[b]) begin
          mem_q[idx][b*8 +: 8] <= mem.wdata[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= mem.valid;
    end
  end

  // Writes and errors answer with zero data
  always_ff @(posedge clk_i) begin
    if (mem.valid) begin
      rdata_q <= ((mem.op == OP_READ) && in_range) ? mem_q[idx] : '0;
      rsp_q   <= in_range ? RSP_OKAY : RSP_ERR;
      rtag_q  <= mem.tag;
    end
  end

  assign mem.rvalid = rvalid_q;
  assign mem.rdata  = rdata_q;
  assign mem.rsp    = rsp_q;
  assign mem.rtag   = rtag_q;

endmodule

// ==== list.f ====
+incdir+bench
design/mem_bus_pkg.sv
design/trace_pkg.sv
design/mem_req_if.sv
design/mem_route.sv
design/bus_to_mem.sv
design/word_sram.sv
design/commit_tracer.sv
design/core_mem_top.sv
bench/tb_core_mem.sv
